// ==== Makefile ====
SIM      := verilator
TOP      := axil_regs_tb
FILELIST := all.f
VFLAGS   := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q ">>> PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+include
design/axil_pkg.sv
design/regfile_pkg.sv
design/axil_channel_accept.sv
design/axil_reg_decode.sv
design/axil_reg_bank.sv
design/axil_resp_drive.sv
design/axil_regs_top.sv
tb/axil_regs_assert.sv
tb/axil_regs_tb.sv

// ==== design/axil_channel_accept.sv ====
`timescale 1ns/1ps

module axil_channel_accept (
    input  logic                  axi_if,
    input  logic                  rst,
    input  axil_pkg::axil_aw_t    aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  axil_pkg::axil_w_t     w,
    input  logic                  wvalid,
    output logic                  wready,
    input  axil_pkg::axil_ar_t    ar,
    input  logic                  arvalid,
    output logic                  arready,
    output regfile_pkg::reg_req_t req,
    output logic                  req_valid,
    input  logic                  req_ready
);

    import axil_pkg::*;

    axil_aw_t aw_slot;
    axil_w_t  w_slot;
    axil_ar_t ar_slot;
    logic     aw_full, w_full, ar_full;
    logic     en;            // readies held low until one cycle after reset
    logic     last_write;    // round-robin state
    logic     wr_ok, rd_ok;
    logic     grant_write;
    logic     issue;

    assign awready = en && !aw_full;
    assign wready  = en && !w_full;
    assign arready = en && !ar_full;

    assign wr_ok = aw_full && w_full;
    assign rd_ok = ar_full;

    // a write wins unless a read is also waiting and a write went last
    assign grant_write = wr_ok && (!rd_ok || !last_write);

    assign req_valid = wr_ok || rd_ok;
    assign issue     = req_valid && req_ready;

    always_comb begin
        req.write = grant_write;
        req.addr  = grant_write ? aw_slot.addr : ar_slot.addr;
        req.data  = grant_write ? w_slot.data : '0;
        req.strb  = grant_write ? w_slot.strb : '0;
    end

    always_ff @(posedge axi_if) begin
        if (rst) begin
            en         <= 1'b0;
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            ar_full    <= 1'b0;
            last_write <= 1'b0;
        end else begin
            en <= 1'b1;
            if (awvalid && awready)
                aw_full <= 1'b1;
            else if (issue && grant_write)
                aw_full <= 1'b0;
            if (wvalid && wready)
                w_full <= 1'b1;
            else if (issue && grant_write)
                w_full <= 1'b0;
            if (arvalid && arready)
                ar_full <= 1'b1;
            else if (issue && !grant_write)
                ar_full <= 1'b0;
            if (issue)
                last_write <= grant_write;
        end
    end

    // slot payloads, captured on the transfer
    always_ff @(posedge axi_if) begin
        if (awvalid && awready) aw_slot <= aw;
        if (wvalid && wready)   w_slot  <= w;
        if (arvalid && arready) ar_slot <= ar;
    end

endmodule

// ==== design/axil_pkg.sv ====
`include "axil_config.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXIL_STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]                  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef struct packed {
        addr_t addr;
    } axil_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        resp_t resp;
    } axil_b_t;

    typedef struct packed {
        addr_t addr;
    } axil_ar_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

endpackage

// ==== design/axil_reg_bank.sv ====
`timescale 1ns/1ps
`include "axil_config.svh"

module axil_reg_bank (
    input  logic                  axi_if,
    input  logic                  rst,
    input  regfile_pkg::reg_cmd_t cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output regfile_pkg::reg_rsp_t rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_ready
);

    import axil_pkg::*;
    import regfile_pkg::*;

    localparam logic [`AXIL_REG_COUNT*`AXIL_DATA_WIDTH-1:0] RESET_VALUES = `AXIL_RESET_VALUES;

    data_t regs [`AXIL_REG_COUNT];
    logic  load;

    assign cmd_ready = !rsp_valid || rsp_ready;
    assign load      = cmd_valid && cmd_ready;

    // storage, written on the same edge the response is loaded
    always_ff @(posedge axi_if) begin
        if (rst) begin
            for (int i = 0; i < `AXIL_REG_COUNT; i++)
                regs[i] <= RESET_VALUES[i*`AXIL_DATA_WIDTH +: `AXIL_DATA_WIDTH];
        end else if (load && cmd.write && !cmd.error) begin
            for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
                if (cmd.strb[b])
                    regs[cmd.index][8*b +: 8] <= cmd.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge axi_if) begin
        if (rst)
            rsp_valid <= 1'b0;
        else if (cmd_ready)
            rsp_valid <= cmd_valid;
    end

    always_ff @(posedge axi_if) begin
        if (load) begin
            rsp.write <= cmd.write;
            rsp.data  <= cmd.error ? `AXIL_ERR_RDATA : regs[cmd.index];   // old value on writes
            rsp.resp  <= cmd.error ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// ==== design/axil_reg_decode.sv ====
`timescale 1ns/1ps
`include "axil_config.svh"

module axil_reg_decode (
    input  logic                  axi_if,
    input  logic                  rst,
    input  regfile_pkg::reg_req_t req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output regfile_pkg::reg_cmd_t cmd,
    output logic                  cmd_valid,
    input  logic                  cmd_ready
);

    import axil_pkg::*;
    import regfile_pkg::*;

    localparam logic [`AXIL_REG_COUNT-1:0] RO_MASK = `AXIL_RO_MASK;

    addr_t      offset;
    logic       aligned;
    logic       in_range;
    logic       read_only;
    reg_index_t index;
    reg_cmd_t   cmd_next;

    assign offset   = req.addr - `AXIL_BASE_ADDR;
    assign aligned  = (offset[1:0] == 2'b00);
    assign in_range = (req.addr >= `AXIL_BASE_ADDR) &&
                      (offset < addr_t'(`AXIL_REG_COUNT * 4));
    assign index    = offset[2 +: `AXIL_REG_INDEX_WIDTH];   // word offset

    // only matters for writes, reads of RO registers are fine
    assign read_only = req.write && RO_MASK[index];

    always_comb begin
        cmd_next.write = req.write;
        cmd_next.index = index;
        cmd_next.data  = req.data;
        cmd_next.strb  = req.strb;
        cmd_next.error = !aligned || !in_range || read_only;
    end

    // load when empty or when the held command leaves this cycle
    assign req_ready = !cmd_valid || cmd_ready;

    always_ff @(posedge axi_if) begin
        if (rst)
            cmd_valid <= 1'b0;
        else if (req_ready)
            cmd_valid <= req_valid;
    end

    always_ff @(posedge axi_if) begin
        if (req_valid && req_ready)
            cmd <= cmd_next;
    end

endmodule

// ==== design/axil_regs_top.sv ====
`timescale 1ns/1ps

module axil_regs_top (
    input  logic               axi_if,
    input  logic               rst,
    input  axil_pkg::axil_aw_t aw,
    input  logic               awvalid,
    output logic               awready,
    input  axil_pkg::axil_w_t  w,
    input  logic               wvalid,
    output logic               wready,
    output axil_pkg::axil_b_t  b,
    output logic               bvalid,
    input  logic               bready,
    input  axil_pkg::axil_ar_t ar,
    input  logic               arvalid,
    output logic               arready,
    output axil_pkg::axil_r_t  r,
    output logic               rvalid,
    input  logic               rready
);

    import regfile_pkg::*;

    reg_req_t req;
    logic     req_valid, req_ready;
    reg_cmd_t cmd;
    logic     cmd_valid, cmd_ready;
    reg_rsp_t rsp;
    logic     rsp_valid, rsp_ready;

    axil_channel_accept u_accept (
        .axi_if(axi_if), .rst(rst),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .req(req), .req_valid(req_valid), .req_ready(req_ready)
    );

    axil_reg_decode u_decode (
        .axi_if(axi_if), .rst(rst),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready)
    );

    axil_reg_bank u_bank (
        .axi_if(axi_if), .rst(rst),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
    );

    axil_resp_drive u_resp (
        .axi_if(axi_if), .rst(rst),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .b(b), .bvalid(bvalid), .bready(bready),
        .r(r), .rvalid(rvalid), .rready(rready)
    );

endmodule

// ==== design/axil_resp_drive.sv ====
`timescale 1ns/1ps

module axil_resp_drive (
    input  logic                  axi_if,
    input  logic                  rst,
    input  regfile_pkg::reg_rsp_t rsp,
    input  logic                  rsp_valid,
    output logic                  rsp_ready,
    output axil_pkg::axil_b_t     b,
    output logic                  bvalid,
    input  logic                  bready,
    output axil_pkg::axil_r_t     r,
    output logic                  rvalid,
    input  logic                  rready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,
        ST_RRESP
    } state_t;

    state_t state;

    assign rsp_ready = (state == ST_IDLE);
    assign bvalid    = (state == ST_WRESP);
    assign rvalid    = (state == ST_RRESP);

    always_ff @(posedge axi_if) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rsp_valid)
                        state <= rsp.write ? ST_WRESP : ST_RRESP;
                end
                ST_WRESP: begin
                    if (bready) state <= ST_IDLE;   // B handshake done
                end
                ST_RRESP: begin
                    if (rready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payloads only change when a new response is taken in
    always_ff @(posedge axi_if) begin
        if (rsp_valid && rsp_ready) begin
            b.resp <= rsp.resp;
            r.data <= rsp.data;
            r.resp <= rsp.resp;
        end
    end

endmodule

// ==== design/regfile_pkg.sv ====
`include "axil_config.svh"

package regfile_pkg;

    typedef logic [`AXIL_REG_INDEX_WIDTH-1:0] reg_index_t;

    // granted request, straight from the channel slots
    typedef struct packed {
        logic            write;
        axil_pkg::addr_t addr;
        axil_pkg::data_t data;
        axil_pkg::strb_t strb;
    } reg_req_t;

    // decoded command
    typedef struct packed {
        logic            write;
        reg_index_t      index;
        axil_pkg::data_t data;
        axil_pkg::strb_t strb;
        logic            error;   // misaligned, out of range or read-only
    } reg_cmd_t;

    typedef struct packed {
        logic            write;
        axil_pkg::data_t data;
        axil_pkg::resp_t resp;
    } reg_rsp_t;

endpackage

// ==== include/axil_config.svh ====
`ifndef AXIL_CONFIG_SVH
`define AXIL_CONFIG_SVH

// bus widths
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// register map
`define AXIL_REG_COUNT 16
`define AXIL_REG_INDEX_WIDTH 4
`define AXIL_BASE_ADDR 32'h0000_0000

// packed reset words, register 0 in the low bits
// order from the top: others, version, config, status, control
`define AXIL_RESET_VALUES {{((`AXIL_REG_COUNT - 4) * `AXIL_DATA_WIDTH){1'b0}}, \
    32'h0001_0000, 32'h0000_0000, 32'hABCD_1234, 32'h0000_0000}

`define AXIL_RO_MASK 16'h000A      // status and version
`define AXIL_ERR_RDATA 32'hDEAD_BEEF

`endif

// ==== tb/axil_regs_assert.sv ====
`timescale 1ns/1ps

module axil_regs_assert (
    input logic              axi_if,
    input logic              rst,
    input axil_pkg::axil_b_t b,
    input logic              bvalid,
    input logic              bready,
    input axil_pkg::axil_r_t r,
    input logic              rvalid,
    input logic              rready
);

    int fail_count = 0;

    b_held: assert property (@(posedge axi_if) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(b))
        else begin
            fail_count++;
            $error("bvalid dropped or b changed before bready");
        end

    r_held: assert property (@(posedge axi_if) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r))
        else begin
            fail_count++;
            $error("rvalid dropped or r changed before rready");
        end

    // state is cleared by the first reset edge
    quiet_in_reset: assert property (@(posedge axi_if) $past(rst) |-> !bvalid && !rvalid)
        else begin
            fail_count++;
            $error("response valid high during reset");
        end

    one_channel: assert property (@(posedge axi_if) disable iff (rst) !(bvalid && rvalid))
        else begin
            fail_count++;
            $error("bvalid and rvalid high together");
        end

endmodule

// ==== tb/axil_regs_tb.sv ====
`timescale 1ns/1ps
`include "axil_config.svh"

module axil_regs_tb;

    import axil_pkg::*;

    localparam int NUM_OPS        = 600;
    localparam int OP_CYCLES      = 30;   // worst case for one operation
    localparam int TIMEOUT_CYCLES = NUM_OPS * OP_CYCLES + 2000;
    localparam logic [`AXIL_REG_COUNT*`AXIL_DATA_WIDTH-1:0] RESET_WORDS = `AXIL_RESET_VALUES;
    localparam logic [`AXIL_REG_COUNT-1:0] RO_MASK = `AXIL_RO_MASK;

    logic     axi_if;
    logic     rst;
    axil_aw_t aw;
    logic     awvalid, awready;
    axil_w_t  w;
    logic     wvalid, wready;
    axil_b_t  b;
    logic     bvalid, bready;
    axil_ar_t ar;
    logic     arvalid, arready;
    axil_r_t  r;
    logic     rvalid, rready;

    data_t  model [`AXIL_REG_COUNT];   // reference copy of the register bank
    integer seed = 41359;
    int     cycles = 0;

    axil_regs_top UUT (.*);

    bind axil_regs_top axil_regs_assert u_assert (.*);

    initial begin
        axi_if = 1'b0;
        forever #2 axi_if = ~axi_if;
    end

    always @(posedge axi_if) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic rand_bit();
        integer v;
        v = $random(seed);
        return v[0];
    endfunction

    function automatic int rand_below(input int n);
        integer v;
        v = $random(seed);
        return int'({1'b0, v[30:0]} % n);
    endfunction

    function automatic addr_t reg_addr(input int idx);
        return `AXIL_BASE_ADDR + addr_t'(idx * 4);
    endfunction

    // SLVERR when misaligned, past the last register, or a write to a read-only one
    function automatic logic addr_error(input addr_t addr, input logic write);
        addr_t off;
        off = addr - `AXIL_BASE_ADDR;
        if (off[1:0] != 2'b00 || off >= addr_t'(`AXIL_REG_COUNT * 4))
            return 1'b1;
        return write && RO_MASK[off[2 +: `AXIL_REG_INDEX_WIDTH]];
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic send_aw(input addr_t addr, input int delay);
        repeat (delay) @(negedge axi_if);
        aw.addr = addr;
        awvalid = 1'b1;
        while (!awready) @(negedge axi_if);
        @(negedge axi_if);
        awvalid = 1'b0;
    endtask

    task automatic send_w(input data_t data, input strb_t strb, input int delay);
        repeat (delay) @(negedge axi_if);
        w.data = data;
        w.strb = strb;
        wvalid = 1'b1;
        while (!wready) @(negedge axi_if);
        @(negedge axi_if);
        wvalid = 1'b0;
    endtask

    task automatic send_ar(input addr_t addr);
        ar.addr = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge axi_if);
        @(negedge axi_if);
        arvalid = 1'b0;
    endtask

    // ready is set at the falling edge, so the transfer lands on the next rising edge
    task automatic get_b(input logic stall, output resp_t resp);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge axi_if);
            bready = stall ? rand_bit() : 1'b1;
            done = bvalid && bready;
        end
        resp = b.resp;
        @(negedge axi_if);
        bready = 1'b0;
    endtask

    task automatic get_r(input logic stall, output axil_r_t got);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge axi_if);
            rready = stall ? rand_bit() : 1'b1;
            done = rvalid && rready;
        end
        got = r;
        @(negedge axi_if);
        rready = 1'b0;
    endtask

    task automatic write_op(input addr_t addr, input data_t data, input strb_t strb,
                            input int aw_delay, input int w_delay, input logic stall);
        resp_t resp;
        logic  err;
        addr_t off;
        fork
            send_aw(addr, aw_delay);
            send_w(data, strb, w_delay);
            get_b(stall, resp);
        join
        err = addr_error(addr, 1'b1);
        off = addr - `AXIL_BASE_ADDR;
        check($sformatf("write %h resp", addr), 32'(err ? RESP_SLVERR : RESP_OKAY), 32'(resp));
        if (!err) begin
            for (int i = 0; i < `AXIL_STRB_WIDTH; i++) begin
                if (strb[i])
                    model[off[2 +: `AXIL_REG_INDEX_WIDTH]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    task automatic read_op(input addr_t addr, input logic stall);
        axil_r_t got;
        addr_t   off;
        logic    err;
        fork
            send_ar(addr);
            get_r(stall, got);
        join
        err = addr_error(addr, 1'b0);
        off = addr - `AXIL_BASE_ADDR;
        check($sformatf("read %h data", addr),
              err ? `AXIL_ERR_RDATA : model[off[2 +: `AXIL_REG_INDEX_WIDTH]], got.data);
        check($sformatf("read %h resp", addr), 32'(err ? RESP_SLVERR : RESP_OKAY), 32'(got.resp));
    endtask

    initial begin
        int    kind;
        int    idx;
        int    other;
        addr_t addr;
        data_t data;
        logic  stall;
        for (int i = 0; i < `AXIL_REG_COUNT; i++)
            model[i] = RESET_WORDS[i*`AXIL_DATA_WIDTH +: `AXIL_DATA_WIDTH];
        rst     = 1'b1;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        bready  = 1'b0;
        rready  = 1'b0;
        repeat (4) @(negedge axi_if);
        check("readies in reset", 32'd0, {29'd0, awready, wready, arready});
        rst = 1'b0;
        @(negedge axi_if);
        // all slots empty one cycle after reset
        check("readies after reset", 32'd7, {29'd0, awready, wready, arready});

        for (int i = 0; i < `AXIL_REG_COUNT; i++)   // reset values
            read_op(reg_addr(i), 1'b0);

        for (int n = 0; n < NUM_OPS; n++) begin
            kind  = rand_below(8);
            idx   = rand_below(`AXIL_REG_COUNT);
            stall = rand_bit();
            data  = $random(seed);
            case (kind)
                0, 1, 2: write_op(reg_addr(idx), data, strb_t'(rand_below(16)),
                                  rand_below(4), rand_below(6), stall);
                3, 4, 5: read_op(reg_addr(idx), stall);
                6: begin
                    // misaligned or past the end of the map
                    if (rand_bit())
                        addr = reg_addr(idx) + addr_t'(1 + rand_below(3));
                    else
                        addr = reg_addr(`AXIL_REG_COUNT) + addr_t'(rand_below(1024) * 4);
                    if (rand_bit())
                        write_op(addr, data, 4'hF, 0, 0, stall);
                    else
                        read_op(addr, stall);
                end
                default: begin
                    other = (idx + 1 + rand_below(`AXIL_REG_COUNT - 1)) % `AXIL_REG_COUNT;
                    fork
                        write_op(reg_addr(idx), data, 4'hF, 0, 0, stall);
                        read_op(reg_addr(other), stall);
                    join
                end
            endcase
        end

        repeat (8) @(negedge axi_if);
        check("no extra response", 32'd0, {30'd0, bvalid, rvalid});
        check("assertion failures", 32'd0, 32'(UUT.u_assert.fail_count));
        $display(">>> PASS");
        $finish;
    end

endmodule
